// File: hdl/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// sizes shared by both caches and the arbiter

`define WORD_SIZE 16    // data and address width
`define LINE_WORDS 4    // words per cache line
`define ICACHE_LINES 4  // direct-mapped, one tag per line
`define DCACHE_LINES 4

`endif

// File: hdl/cache_pkg.sv
package cache_pkg;

	// cache controller state
	// icache never enters cache_write
	typedef enum logic [1:0] {
		cache_idle,
		cache_fill,  // line refill, one word per request
		cache_write  // single word write-through
	} cache_state_e;

	typedef enum logic {
		mem_read,
		mem_write
	} mem_op_e;

	// APB master phases
	typedef enum logic [1:0] {
		arb_idle,
		arb_setup,
		arb_access
	} arb_state_e;

endpackage

// File: hdl/icache.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module icache
	import cache_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  fetch_req,
	input  logic [`WORD_SIZE-1:0] fetch_addr,
	output logic [`WORD_SIZE-1:0] fetch_data,
	output logic                  fetch_valid,
	output logic                  mreq,
	output logic [`WORD_SIZE-1:0] maddr,
	input  logic                  mack,
	input  logic [`WORD_SIZE-1:0] mrdata
);

	localparam int OFF_W = $clog2(`LINE_WORDS);
	localparam int IDX_W = $clog2(`ICACHE_LINES);
	localparam int TAG_W = `WORD_SIZE - OFF_W - IDX_W;
	localparam int CNT_W = OFF_W + 1;  // holds LINE_WORDS itself

	cache_state_e state;
	logic [CNT_W-1:0] remain;  // words still to fetch
	logic [`ICACHE_LINES-1:0] valid;
	logic [TAG_W-1:0] tag_arr [`ICACHE_LINES];
	logic [`WORD_SIZE-1:0] data_arr [`ICACHE_LINES][`LINE_WORDS];

	logic [TAG_W-1:0] req_tag;
	logic [IDX_W-1:0] req_idx;
	logic [OFF_W-1:0] req_off;
	logic [OFF_W-1:0] fill_off;
	logic hit;
	logic lookup;

	assign req_tag = fetch_addr[`WORD_SIZE-1 -: TAG_W];
	assign req_idx = fetch_addr[OFF_W +: IDX_W];
	assign req_off = fetch_addr[OFF_W-1:0];
	assign hit = valid[req_idx] && (tag_arr[req_idx] == req_tag);

	// skip the cycle where the previous answer is still showing
	assign lookup = (state == cache_idle) && fetch_req && !fetch_valid;

	// word 0 goes out first, then 1, 2, 3
	assign fill_off = OFF_W'(`LINE_WORDS - remain);

	assign mreq = (state == cache_fill);
	assign maddr = {fetch_addr[`WORD_SIZE-1:OFF_W], fill_off};  // aligned base plus offset

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cache_idle;
			remain <= '0;
			valid <= '0;
			fetch_valid <= 1'b0;
		end else begin
			fetch_valid <= 1'b0;  // one cycle pulse
			case (state)
				cache_idle: begin
					if (lookup) begin
						if (hit) begin
							fetch_valid <= 1'b1;
						end else begin
							valid[req_idx] <= 1'b0;  // line is being replaced
							remain <= CNT_W'(`LINE_WORDS);
							state <= cache_fill;
						end
					end
				end
				cache_fill: begin
					if (mack) begin
						remain <= remain - 1'b1;
						if (remain == CNT_W'(1)) begin
							valid[req_idx] <= 1'b1;
							state <= cache_idle;  // lookup hits on the next cycle
						end
					end
				end
				default: begin
					state <= cache_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lookup && hit) begin
			fetch_data <= data_arr[req_idx][req_off];
		end
		if (lookup && !hit) begin
			tag_arr[req_idx] <= req_tag;
		end
		if (state == cache_fill && mack) begin
			data_arr[req_idx][fill_off] <= mrdata;
		end
	end

endmodule

// File: hdl/dcache.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module dcache
	import cache_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  rd_req,
	input  logic                  wr_req,
	input  logic [`WORD_SIZE-1:0] data_addr,
	input  logic [`WORD_SIZE-1:0] wdata,
	output logic [`WORD_SIZE-1:0] rdata,
	output logic                  done,
	output logic                  mreq,
	output mem_op_e               mop,
	output logic [`WORD_SIZE-1:0] maddr,
	output logic [`WORD_SIZE-1:0] mwdata,
	input  logic                  mack,
	input  logic [`WORD_SIZE-1:0] mrdata
);

	localparam int OFF_W = $clog2(`LINE_WORDS);
	localparam int IDX_W = $clog2(`DCACHE_LINES);
	localparam int TAG_W = `WORD_SIZE - OFF_W - IDX_W;
	localparam int CNT_W = OFF_W + 1;

	cache_state_e state;
	logic [CNT_W-1:0] remain;  // refill words left
	logic [`DCACHE_LINES-1:0] valid;
	logic [TAG_W-1:0] tag_arr [`DCACHE_LINES];
	logic [`WORD_SIZE-1:0] data_arr [`DCACHE_LINES][`LINE_WORDS];

	logic [TAG_W-1:0] req_tag;
	logic [IDX_W-1:0] req_idx;
	logic [OFF_W-1:0] req_off;
	logic [OFF_W-1:0] fill_off;
	logic hit;
	logic rd_lookup;
	logic wr_start;

	assign req_tag = data_addr[`WORD_SIZE-1 -: TAG_W];
	assign req_idx = data_addr[OFF_W +: IDX_W];
	assign req_off = data_addr[OFF_W-1:0];
	assign hit = valid[req_idx] && (tag_arr[req_idx] == req_tag);

	// reads win if both are raised
	assign rd_lookup = (state == cache_idle) && rd_req && !done;
	assign wr_start = (state == cache_idle) && wr_req && !rd_req && !done;

	assign fill_off = OFF_W'(`LINE_WORDS - remain);

	assign mreq = (state != cache_idle);
	assign mop = (state == cache_write) ? mem_write : mem_read;
	assign maddr = (state == cache_write) ? data_addr
		: {data_addr[`WORD_SIZE-1:OFF_W], fill_off};
	assign mwdata = wdata;  // held by the processor until done

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cache_idle;
			remain <= '0;
			valid <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				cache_idle: begin
					if (rd_lookup) begin
						if (hit) begin
							done <= 1'b1;
						end else begin
							valid[req_idx] <= 1'b0;
							remain <= CNT_W'(`LINE_WORDS);
							state <= cache_fill;
						end
					end else if (wr_start) begin
						state <= cache_write;
					end
				end
				cache_fill: begin
					if (mack) begin
						remain <= remain - 1'b1;
						if (remain == CNT_W'(1)) begin
							valid[req_idx] <= 1'b1;
							state <= cache_idle;
						end
					end
				end
				cache_write: begin
					if (mack) begin  // memory has the word now
						done <= 1'b1;
						state <= cache_idle;
					end
				end
				default: begin
					state <= cache_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_lookup && hit) begin
			rdata <= data_arr[req_idx][req_off];
		end
		if (rd_lookup && !hit) begin
			tag_arr[req_idx] <= req_tag;
		end
		if (state == cache_fill && mack) begin
			data_arr[req_idx][fill_off] <= mrdata;
		end
		// write hit keeps the cached copy current, a miss leaves it alone
		if (state == cache_write && mack && hit) begin
			data_arr[req_idx][req_off] <= wdata;
		end
	end

endmodule

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module mem_arbiter
	import cache_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  ic_mreq,
	input  logic [`WORD_SIZE-1:0] ic_maddr,
	input  logic                  dc_mreq,
	input  mem_op_e               dc_mop,
	input  logic [`WORD_SIZE-1:0] dc_maddr,
	input  logic [`WORD_SIZE-1:0] dc_mwdata,
	output logic                  ic_mack,
	output logic                  dc_mack,
	output logic [`WORD_SIZE-1:0] mrdata,
	output logic                  psel,
	output logic                  penable,
	output logic                  pwrite,
	output logic [`WORD_SIZE-1:0] paddr,
	output logic [`WORD_SIZE-1:0] pwdata,
	input  logic [`WORD_SIZE-1:0] prdata,
	input  logic                  pready
);

	arb_state_e state;
	logic last_dc;  // dcache holds or last held the grant
	logic ic_want;
	logic dc_want;
	logic pick_dc;

	// a request whose mack is showing is the one just served
	assign ic_want = ic_mreq && !ic_mack;
	assign dc_want = dc_mreq && !dc_mack;

	assign pick_dc = dc_want && (!ic_want || !last_dc);

	assign psel = (state != arb_idle);
	assign penable = (state == arb_access);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= arb_idle;
			last_dc <= 1'b0;
			pwrite <= 1'b0;
			ic_mack <= 1'b0;
			dc_mack <= 1'b0;
		end else begin
			ic_mack <= 1'b0;
			dc_mack <= 1'b0;
			case (state)
				arb_idle: begin
					if (ic_want || dc_want) begin
						last_dc <= pick_dc;
						pwrite <= pick_dc && (dc_mop == mem_write);
						state <= arb_setup;
					end
				end
				arb_setup: begin
					state <= arb_access;
				end
				arb_access: begin
					if (pready) begin  // stall otherwise, request stays held
						dc_mack <= last_dc;
						ic_mack <= !last_dc;
						state <= arb_idle;
					end
				end
				default: begin
					state <= arb_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == arb_idle && (ic_want || dc_want)) begin
			paddr <= pick_dc ? dc_maddr : ic_maddr;
			pwdata <= dc_mwdata;
		end
		if (state == arb_access && pready) begin
			mrdata <= prdata;
		end
	end

endmodule

// File: hdl/mem_subsys.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module mem_subsys
	import cache_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  fetch_req,
	input  logic [`WORD_SIZE-1:0] fetch_addr,
	output logic [`WORD_SIZE-1:0] fetch_data,
	output logic                  fetch_valid,
	input  logic                  rd_req,
	input  logic                  wr_req,
	input  logic [`WORD_SIZE-1:0] data_addr,
	input  logic [`WORD_SIZE-1:0] wdata,
	output logic [`WORD_SIZE-1:0] rdata,
	output logic                  done,
	output logic                  psel,
	output logic                  penable,
	output logic                  pwrite,
	output logic [`WORD_SIZE-1:0] paddr,
	output logic [`WORD_SIZE-1:0] pwdata,
	input  logic [`WORD_SIZE-1:0] prdata,
	input  logic                  pready
);

	logic ic_mreq;
	logic [`WORD_SIZE-1:0] ic_maddr;
	logic ic_mack;
	logic dc_mreq;
	mem_op_e dc_mop;
	logic [`WORD_SIZE-1:0] dc_maddr;
	logic [`WORD_SIZE-1:0] dc_mwdata;
	logic dc_mack;
	logic [`WORD_SIZE-1:0] mrdata;  // shared, qualified by each mack

	icache icache_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.fetch_data  (fetch_data),
		.fetch_valid (fetch_valid),
		.mreq        (ic_mreq),
		.maddr       (ic_maddr),
		.mack        (ic_mack),
		.mrdata      (mrdata)
	);

	dcache dcache_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.data_addr (data_addr),
		.wdata     (wdata),
		.rdata     (rdata),
		.done      (done),
		.mreq      (dc_mreq),
		.mop       (dc_mop),
		.maddr     (dc_maddr),
		.mwdata    (dc_mwdata),
		.mack      (dc_mack),
		.mrdata    (mrdata)
	);

	mem_arbiter arbiter_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.ic_mreq   (ic_mreq),
		.ic_maddr  (ic_maddr),
		.dc_mreq   (dc_mreq),
		.dc_mop    (dc_mop),
		.dc_maddr  (dc_maddr),
		.dc_mwdata (dc_mwdata),
		.ic_mack   (ic_mack),
		.dc_mack   (dc_mack),
		.mrdata    (mrdata),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready)
	);

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic arst_n
);

	localparam int HALF_PERIOD_NS = 2;  // 4 ns clock
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD_NS clk = ~clk;
		end
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;  // released between edges
	end

endmodule

// File: tb/apb_mem_slave.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module apb_mem_slave #(
	parameter int SEED = 25163
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  logic [`WORD_SIZE-1:0] paddr,
	input  logic [`WORD_SIZE-1:0] pwdata,
	output logic [`WORD_SIZE-1:0] prdata,
	output logic                  pready,
	output logic                  proto_err
);

	localparam logic [`WORD_SIZE-1:0] FILL_MUL = 16'h9e37;  // odd, so every address differs
	localparam logic [`WORD_SIZE-1:0] FILL_XOR = 16'h5a3c;

	logic [`WORD_SIZE-1:0] shadow [2**`WORD_SIZE];  // last value written per address
	logic written [2**`WORD_SIZE];
	int seed;
	logic prev_psel;
	logic prev_penable;
	logic prev_pready;
	logic prev_pwrite;
	logic [`WORD_SIZE-1:0] prev_paddr;
	logic [`WORD_SIZE-1:0] prev_pwdata;

	function automatic logic [`WORD_SIZE-1:0] stored_word(input logic [`WORD_SIZE-1:0] addr);
		if (written[addr]) begin
			return shadow[addr];
		end
		return (addr * FILL_MUL) ^ FILL_XOR;  // power-up contents
	endfunction

	task automatic flag_violation(input string what);
		$display("APB protocol error at %0t: %s", $time, what);
		proto_err = 1'b1;
	endtask

	initial begin
		seed = SEED;
		prdata = '0;
		pready = 1'b0;
		proto_err = 1'b0;
		foreach (written[i]) begin
			written[i] = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (psel && penable) begin
			pready = ($random(seed) & 3) != 0;  // stall about one cycle in four
			prdata = stored_word(paddr);
		end else begin
			pready = 1'b0;
		end
	end

	always @(posedge clk) begin
		if (!arst_n) begin
			prev_psel = 1'b0;
			prev_penable = 1'b0;
			prev_pready = 1'b0;
			prev_pwrite = 1'b0;
			prev_paddr = '0;
			prev_pwdata = '0;
		end else begin
			if (penable) begin
				assert (psel && prev_psel && !(prev_penable && prev_pready))
				else flag_violation("penable rose without a setup cycle first");
				assert (paddr === prev_paddr && pwrite === prev_pwrite && pwdata === prev_pwdata)
				else flag_violation("paddr, pwrite or pwdata changed during the access phase");
			end
			if (prev_psel && !psel) begin
				assert (prev_penable && prev_pready)
				else flag_violation("psel dropped before pready");
			end
			if (psel && penable && pready && pwrite) begin
				shadow[paddr] = pwdata;
				written[paddr] = 1'b1;
			end
			prev_psel = psel;
			prev_penable = penable;
			prev_pready = pready;
			prev_pwrite = pwrite;
			prev_paddr = paddr;
			prev_pwdata = pwdata;
		end
	end

endmodule

// File: tb/mem_subsys_tb.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module mem_subsys_tb;

	parameter int SEED = 25163;

	localparam int NUM_OPS = 200;
	localparam int TIMEOUT_CYCLES = 400;
	localparam logic [`WORD_SIZE-1:0] FILL_MUL = 16'h9e37;
	localparam logic [`WORD_SIZE-1:0] FILL_XOR = 16'h5a3c;
	localparam logic [`WORD_SIZE-1:0] CODE_BASE = 16'h1000;  // code and data never overlap
	localparam logic [`WORD_SIZE-1:0] DATA_BASE = 16'h8000;

	logic clk;
	logic arst_n;
	logic fetch_req;
	logic [`WORD_SIZE-1:0] fetch_addr;
	logic [`WORD_SIZE-1:0] fetch_data;
	logic fetch_valid;
	logic rd_req;
	logic wr_req;
	logic [`WORD_SIZE-1:0] data_addr;
	logic [`WORD_SIZE-1:0] wdata;
	logic [`WORD_SIZE-1:0] rdata;
	logic done;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`WORD_SIZE-1:0] paddr;
	logic [`WORD_SIZE-1:0] pwdata;
	logic [`WORD_SIZE-1:0] prdata;
	logic pready;
	logic proto_err;
	logic [`WORD_SIZE:0] apb_log [$];  // {pwrite, paddr} per finished transfer
	int seed;

	clk_gen clk_gen_i (.clk(clk), .arst_n(arst_n));

	apb_mem_slave #(.SEED(SEED)) mem_i (
		.clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.proto_err(proto_err)
	);

	mem_subsys dut_i (
		.clk(clk), .arst_n(arst_n), .fetch_req(fetch_req), .fetch_addr(fetch_addr),
		.fetch_data(fetch_data), .fetch_valid(fetch_valid), .rd_req(rd_req),
		.wr_req(wr_req), .data_addr(data_addr), .wdata(wdata), .rdata(rdata),
		.done(done), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready)
	);

	function automatic logic [`WORD_SIZE-1:0] mem_init_word(input logic [`WORD_SIZE-1:0] addr);
		return (addr * FILL_MUL) ^ FILL_XOR;
	endfunction

	function automatic logic [`WORD_SIZE-1:0] expected_word(input logic [`WORD_SIZE-1:0] addr);
		if (mem_i.written[addr]) begin
			return mem_i.shadow[addr];
		end
		return mem_init_word(addr);
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [`WORD_SIZE-1:0] got,
			input logic [`WORD_SIZE-1:0] expv);
		fail_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, expv));
	endtask

	task automatic check_transfer_count(input int expect_n, input string what);
		assert (apb_log.size() == expect_n)
		else fail_run($sformatf("%s expected %0d APB transfers but saw %0d",
			what, expect_n, apb_log.size()));
	endtask

	task automatic wait_fetch_valid(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (cycles <= TIMEOUT_CYCLES) else fail_run("timeout waiting for fetch_valid");
		end while (!fetch_valid);
	endtask

	task automatic wait_done(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (cycles <= TIMEOUT_CYCLES) else fail_run("timeout waiting for done");
		end while (!done);
	endtask

	task automatic fetch(input logic [`WORD_SIZE-1:0] addr, output int cycles);
		fetch_addr = addr;
		fetch_req = 1'b1;
		wait_fetch_valid(cycles);
		@(negedge clk);  // held through the valid cycle
		fetch_req = 1'b0;
	endtask

	task automatic data_read(input logic [`WORD_SIZE-1:0] addr, output int cycles);
		data_addr = addr;
		rd_req = 1'b1;
		wait_done(cycles);
		@(negedge clk);
		rd_req = 1'b0;
	endtask

	task automatic data_write(input logic [`WORD_SIZE-1:0] addr,
			input logic [`WORD_SIZE-1:0] value, output int cycles);
		data_addr = addr;
		wdata = value;
		wr_req = 1'b1;
		wait_done(cycles);
		@(negedge clk);
		wr_req = 1'b0;
	endtask

	always @(posedge clk) begin
		if (psel && penable && pready) begin
			apb_log.push_back({pwrite, paddr});
		end
	end

	always @(posedge proto_err) begin
		fail_run("the memory model saw an APB protocol violation");
	end

	// every answer is held against the reference memory
	always @(negedge clk) begin
		if (arst_n && fetch_valid) begin
			assert (fetch_data === expected_word(fetch_addr))
			else report_mismatch("fetch_data", fetch_data, expected_word(fetch_addr));
		end
		if (arst_n && done && rd_req) begin
			assert (rdata === expected_word(data_addr))
			else report_mismatch("rdata", rdata, expected_word(data_addr));
		end
		if (arst_n && done && wr_req) begin
			assert (expected_word(data_addr) === wdata)
			else report_mismatch("shadow[data_addr]", expected_word(data_addr), wdata);
		end
	end

	initial begin
		int cycles;
		int c_data;
		int rnd;
		logic [`WORD_SIZE-1:0] base;
		logic [`WORD_SIZE-1:0] c_addr;
		logic [`WORD_SIZE-1:0] d_addr;

		fetch_req = 1'b0;
		fetch_addr = '0;
		rd_req = 1'b0;
		wr_req = 1'b0;
		data_addr = '0;
		wdata = '0;
		seed = SEED;

		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			assert (cycles <= TIMEOUT_CYCLES) else fail_run("timeout waiting for reset release");
		end while (!arst_n);
		assert (fetch_valid === 1'b0) else report_mismatch("fetch_valid", fetch_valid, 0);
		assert (done === 1'b0) else report_mismatch("done", done, 0);
		assert (psel === 1'b0) else report_mismatch("psel", psel, 0);
		assert (penable === 1'b0) else report_mismatch("penable", penable, 0);

		// instruction miss fills the whole line in order
		base = CODE_BASE + 16'h0004;
		apb_log.delete();
		fetch(base + 16'h0002, cycles);
		check_transfer_count(`LINE_WORDS, "instruction line fill");
		for (int i = 0; i < `LINE_WORDS; i++) begin
			assert (apb_log[i][`WORD_SIZE] === 1'b0)
			else report_mismatch("pwrite", apb_log[i][`WORD_SIZE], 0);
			assert (apb_log[i][`WORD_SIZE-1:0] === base + 16'(i))
			else report_mismatch("paddr", apb_log[i][`WORD_SIZE-1:0], base + 16'(i));
		end
		apb_log.delete();
		fetch(base + 16'h0001, cycles);
		assert (cycles == 1)
		else fail_run($sformatf("fetch hit took %0d cycles instead of 1", cycles));
		check_transfer_count(0, "fetch hit");

		// write-through, no allocate on a write miss
		apb_log.delete();
		data_write(DATA_BASE + 16'h0002, 16'hbeef, cycles);
		check_transfer_count(1, "write miss");
		apb_log.delete();
		data_read(DATA_BASE + 16'h0002, cycles);
		check_transfer_count(`LINE_WORDS, "read after a write miss");
		data_write(DATA_BASE + 16'h0003, 16'h1234, cycles);
		data_read(DATA_BASE + 16'h0003, cycles);
		assert (cycles == 1)
		else fail_run($sformatf("read hit took %0d cycles instead of 1", cycles));
		data_read(DATA_BASE + 16'h0012, cycles);  // same index, evicts the line
		apb_log.delete();
		data_read(DATA_BASE + 16'h0003, cycles);
		check_transfer_count(`LINE_WORDS, "read after eviction");

		// both caches miss in the same cycle
		apb_log.delete();
		fork
			fetch(CODE_BASE + 16'h0021, cycles);
			data_read(DATA_BASE + 16'h0031, c_data);
		join
		check_transfer_count(2 * `LINE_WORDS, "concurrent misses");
		for (int i = 1; i < apb_log.size(); i++) begin
			assert (apb_log[i][`WORD_SIZE-1] != apb_log[i-1][`WORD_SIZE-1])
			else fail_run("the two caches did not take turns on the APB port");
		end

		for (int n = 0; n < NUM_OPS; n++) begin
			rnd = $random(seed);
			c_addr = CODE_BASE + 16'(rnd[5:0]);
			d_addr = DATA_BASE + 16'(rnd[13:8]);
			case (rnd[17:16])
				2'd0: fetch(c_addr, cycles);
				2'd1: data_read(d_addr, cycles);
				2'd2: data_write(d_addr, rnd[31:16], cycles);
				default: begin
					fork
						fetch(c_addr, cycles);
						data_read(d_addr, c_data);
					join
				end
			endcase
		end

		if (!proto_err) begin
			$display("** PASS **");
			$finish;
		end else begin
			fail_run("an APB protocol violation was flagged");
		end
	end

endmodule

// File: cache_mem.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/mem_arbiter.sv
hdl/mem_subsys.sv
tb/clk_gen.sv
tb/apb_mem_slave.sv
tb/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
RTL_TOP   ?= mem_subsys
SEED      ?= 25163
LOG       ?= sim.log
FILELIST  ?= cache_mem.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR)

sim: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
